//--- bench/decodeStageTb.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStageTb;

    localparam int resetCycles = 8;
    localparam string caseFile = "bench/decode_cases.txt";

    logic                 clk = 1'b0;
    logic                 rstN;
    decodePkg::instrWordU instr;
    logic                 instrValid;
    logic                 outValid;
    decodePkg::ctlT       ctl;
    decodePkg::regUseT    regUse;
    decodePkg::xWord      imm;

    // cases as read from the file
    decodePkg::instrWordU instrQ[$];
    logic                 validQ[$];
    decodePkg::ctlT       ctlQ[$];
    decodePkg::regUseT    regUseQ[$];
    decodePkg::xWord      immQ[$];

    int cycleCount = 0;
    int cycleLimit = resetCycles + 20;

    decodeStage u_dut (
        .clk        (clk),
        .rstN       (rstN),
        .instr      (instr),
        .instrValid (instrValid),
        .outValid   (outValid),
        .ctl        (ctl),
        .regUse     (regUse),
        .imm        (imm)
    );

    always #4 clk = ~clk;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            abortRun($sformatf("timeout: no verdict after %0d cycles", cycleCount));
        end
    end

    // first field that differs, for the error line
    function automatic string ctlFieldName(input decodePkg::ctlT got, input decodePkg::ctlT exp);
        if (got.regWrite !== exp.regWrite) return "regWrite";
        if (got.memRead !== exp.memRead) return "memRead";
        if (got.memWrite !== exp.memWrite) return "memWrite";
        if (got.memToReg !== exp.memToReg) return "memToReg";
        if (got.readCsr !== exp.readCsr) return "readCsr";
        if (got.writeCsr !== exp.writeCsr) return "writeCsr";
        if (got.isCsr !== exp.isCsr) return "isCsr";
        if (got.csrFromZimm !== exp.csrFromZimm) return "csrFromZimm";
        if (got.aluFunc !== exp.aluFunc) return "aluFunc";
        if (got.aluSrc !== exp.aluSrc) return "aluSrc";
        if (got.immKind !== exp.immKind) return "immKind";
        if (got.memSize !== exp.memSize) return "memSize";
        if (got.wbKind !== exp.wbKind) return "wbKind";
        return "branchType";
    endfunction

    task automatic checkCtl(input decodePkg::ctlT got, input decodePkg::ctlT exp, input string tag);
        if (got !== exp) begin
            abortRun($sformatf("CHECK FAILED at %0t: %s ctl.%s got %h expected %h",
                               $time, tag, ctlFieldName(got, exp), got, exp));
        end
    endtask

    task automatic checkRegUse(input decodePkg::regUseT got, input decodePkg::regUseT exp,
                               input string tag);
        if (got !== exp) begin
            abortRun($sformatf("CHECK FAILED at %0t: %s regUse got %0d expected %0d",
                               $time, tag, got, exp));
        end
    endtask

    task automatic checkImm(input decodePkg::xWord got, input decodePkg::xWord exp, input string tag);
        if (got !== exp) begin
            abortRun($sformatf("CHECK FAILED at %0t: %s imm got %h expected %h",
                               $time, tag, got, exp));
        end
    endtask

    task automatic checkValid(input logic got, input logic exp, input string tag);
        if (got !== exp) begin
            abortRun($sformatf("CHECK FAILED at %0t: %s outValid got %b expected %b",
                               $time, tag, got, exp));
        end
    endtask

    // reset state: everything reads zero
    task automatic checkIdle(input string tag);
        checkValid(outValid, 1'b0, tag);
        checkCtl(ctl, '0, tag);
        checkRegUse(regUse, decodePkg::noRs, tag);
        checkImm(imm, '0, tag);
    endtask

    task automatic loadCases();
        int                   fd;
        int                   got;
        string                line;
        decodePkg::instrWordU word;
        logic                 valid;
        logic [7:0]           flags;
        logic [4:0]           aluF;
        logic [2:0]           aluS;
        logic [2:0]           immK;
        logic [2:0]           memS;
        logic [2:0]           wbK;
        logic [3:0]           brT;
        logic [1:0]           useK;
        decodePkg::xWord      immVal;
        decodePkg::ctlT       exp;
        fd = $fopen(caseFile, "r");
        if (fd == 0) begin
            abortRun("could not open the case file bench/decode_cases.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 8 || line.getc(0) == "#") begin
                continue;
            end
            got = $sscanf(line, "%h %b %b %d %d %d %d %d %d %d %h", word, valid, flags,
                          aluF, aluS, immK, memS, wbK, brT, useK, immVal);
            if (got != 11) begin
                abortRun($sformatf("malformed line in the case file: %s", line));
            end
            exp = '0;
            {exp.regWrite, exp.memRead, exp.memWrite, exp.memToReg,
             exp.readCsr, exp.writeCsr, exp.isCsr, exp.csrFromZimm} = flags;
            exp.aluFunc    = decodePkg::aluFuncT'(aluF);
            exp.aluSrc     = decodePkg::aluSrcT'(aluS);
            exp.immKind    = decodePkg::immKindT'(immK);
            exp.memSize    = decodePkg::memSizeT'(memS);
            exp.wbKind     = decodePkg::wbKindT'(wbK);
            exp.branchType = decodePkg::branchT'(brT);
            instrQ.push_back(word);
            validQ.push_back(valid);
            ctlQ.push_back(exp);
            regUseQ.push_back(decodePkg::regUseT'(useK));
            immQ.push_back(immVal);
        end
        $fclose(fd);
    endtask

    initial begin
        int    i;
        string tag;
        rstN       = 1'b0;
        instr      = '0;
        instrValid = 1'b0;
        loadCases();
        cycleLimit = resetCycles + 4 * instrQ.size() + 20;

        repeat (resetCycles) begin
            @(posedge clk);
            #1;
            checkIdle("during reset");
        end
        rstN = 1'b1;
        @(posedge clk);
        #1;
        checkIdle("after reset");

        // drive one case per cycle, check it on the next edge
        for (i = 0; i < instrQ.size(); i++) begin
            instr      = instrQ[i];
            instrValid = validQ[i];
            @(posedge clk);
            #1;
            tag = $sformatf("case %0d", i);
            checkValid(outValid, validQ[i], tag);
            checkCtl(ctl, ctlQ[i], tag);
            checkRegUse(regUse, regUseQ[i], tag);
            checkImm(imm, immQ[i], tag);
        end
        instrValid = 1'b0;
        @(posedge clk);
        #1;
        checkValid(outValid, 1'b0, "drain");

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/decode_cases.txt
# instr valid flags(regWrite memRead memWrite memToReg readCsr writeCsr isCsr csrFromZimm)
# then decimal codes aluFunc aluSrc immKind memSize wbKind branchType regUse, then imm in hex
FFB10093 1 10000000  0 2 1 0 0 0 1 FFFFFFFFFFFFFFFB addi x1,x2,-5
00721193 1 10000000  7 3 0 0 0 0 1 0000000000000000 slli x3,x4,7
40335293 1 10000000  9 3 0 0 0 0 1 0000000000000000 srai x5,x6,3
7FF44393 1 10000000  2 2 1 0 0 0 1 00000000000007FF xori x7,x8,2047
003100B3 1 10000000  0 1 0 0 0 0 2 0000000000000000 add x1,x2,x3
403100B3 1 10000000  1 1 0 0 0 0 2 0000000000000000 sub x1,x2,x3
0062B233 1 10000000  6 1 0 0 0 0 2 0000000000000000 sltu x4,x5,x6
409453B3 1 10000000  9 1 0 0 0 0 2 0000000000000000 sra x7,x8,x9
FFF5851B 1 10000000 10 2 1 0 0 0 1 FFFFFFFFFFFFFFFF addiw x10,x11,-1
4046D61B 1 10000000 14 3 0 0 0 0 1 0000000000000000 sraiw x12,x13,4
4107873B 1 10000000 11 1 0 0 0 0 2 0000000000000000 subw x14,x15,x16
003110BB 1 10000000 12 1 0 0 0 0 2 0000000000000000 sllw x1,x2,x3
FFC10083 1 11010000  0 2 1 1 5 0 1 FFFFFFFFFFFFFFFC lb x1,-4(x2)
01026183 1 11010000  0 2 1 3 3 0 1 0000000000000010 lwu x3,16(x4)
00833283 1 11010000  0 2 1 4 4 0 1 0000000000000008 ld x5,8(x6)
00837283 1 11010000  0 2 1 0 0 0 1 0000000000000008 load with funct3 7
FE743C23 1 00100000  0 2 4 4 0 0 2 FFFFFFFFFFFFFFF8 sd x7,-8(x8)
009502A3 1 00100000  0 2 4 1 0 0 2 0000000000000005 sb x9,5(x10)
00208863 1 00000000 15 1 3 0 0 1 2 0000000000000010 beq x1,x2,16
FE41ECE3 1 00000000 15 1 3 0 0 4 2 FFFFFFFFFFFFFFF8 bltu x3,x4,-8
0062D0E3 1 00000000 15 1 3 0 0 5 2 0000000000000800 bge x5,x6,2048
0020A863 1 00000000 15 1 3 0 0 0 2 0000000000000010 branch with funct3 2
800000B7 1 10000000 16 2 2 0 0 0 0 FFFFFFFF80000000 lui x1,0x80000
12345117 1 10000000 16 4 2 0 0 0 0 0000000012345000 auipc x2,0x12345
FFDFF0EF 1 10000000 16 5 5 0 0 7 0 FFFFFFFFFFFFFFFC jal x1,-4
00008067 1 10000000 16 5 1 0 0 8 1 0000000000000000 jalr x0,0(x1)
300110F3 1 10001110 17 6 0 0 0 0 1 0000000000000000 csrrw x1,0x300,x2
3002E1F3 1 10001111  3 6 6 0 0 0 0 0000000000000005 csrrsi x3,0x300,5
3412B273 1 10001110  4 6 0 0 0 0 1 0000000000000000 csrrc x4,0x341,x5
341FF373 1 10001111  4 6 6 0 0 0 0 000000000000001F csrrci x6,0x341,31
003100B3 0 10001111  4 6 6 0 0 0 0 000000000000001F valid low, csrrci data held
FFFFFFFF 1 00000000 18 1 0 0 0 0 0 0000000000000000 unknown opcode
300040F3 1 10001110 18 6 0 0 0 0 0 0000000000000000 system with funct3 4
300050F3 1 10001111 17 6 6 0 0 0 0 0000000000000000 csrrwi x1,0x300,0

//--- common/decodePkg.sv
`default_nettype none

`include "decode_defs.svh"

package decodePkg;

    typedef logic [`XLEN-1:0] xWord;

    // format views, msb first
    typedef struct packed {
        logic [`F7_W-1:0]  funct7;
        logic [`REG_W-1:0] rs2;
        logic [`REG_W-1:0] rs1;
        logic [`F3_W-1:0]  funct3;
        logic [`REG_W-1:0] rd;
        logic [`OPC_W-1:0] opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0]       imm;
        logic [`REG_W-1:0] rs1;
        logic [`F3_W-1:0]  funct3;
        logic [`REG_W-1:0] rd;
        logic [`OPC_W-1:0] opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0]        immHi;
        logic [`REG_W-1:0] rs2;
        logic [`REG_W-1:0] rs1;
        logic [`F3_W-1:0]  funct3;
        logic [4:0]        immLo;
        logic [`OPC_W-1:0] opcode;
    } sTypeT;

    typedef struct packed {
        logic              imm12;
        logic [5:0]        imm10to5;
        logic [`REG_W-1:0] rs2;
        logic [`REG_W-1:0] rs1;
        logic [`F3_W-1:0]  funct3;
        logic [3:0]        imm4to1;
        logic              imm11;
        logic [`OPC_W-1:0] opcode;
    } bTypeT;

    typedef struct packed {
        logic [19:0]       imm;
        logic [`REG_W-1:0] rd;
        logic [`OPC_W-1:0] opcode;
    } uTypeT;

    typedef struct packed {
        logic              imm20;
        logic [9:0]        imm10to1;
        logic              imm11;
        logic [7:0]        imm19to12;
        logic [`REG_W-1:0] rd;
        logic [`OPC_W-1:0] opcode;
    } jTypeT;

    typedef union packed {
        rTypeT rType;
        iTypeT iType;
        sTypeT sType;
        bTypeT bType;
        uTypeT uType;
        jTypeT jType;
    } instrWordU;

    typedef enum logic [3:0] {
        illegal, opImm, op, opImm32, op32, load, store,
        branch, lui, auipc, jal, jalr, csr
    } instrClassT;

    typedef enum logic [1:0] {noRs, onlyRs1, bothRs} regUseT;

    typedef enum logic [4:0] {
        aluAdd, aluSub, aluXor, aluOr, aluAnd, aluSlt, aluSltu,
        aluSll, aluSrl, aluSra, aluAddw, aluSubw, aluSllw, aluSrlw, aluSraw,
        aluBranch, aluLink, aluPassRs1, aluUnknown
    } aluFuncT;

    typedef enum logic [2:0] {
        noSrc, fromReg, fromImm, fromShamt, fromPcAddImm, fromPcAdd4, fromCsr
    } aluSrcT;

    typedef enum logic [2:0] {immNone, iImm, uImm, bImm, sImm, jImm, csrZimm} immKindT;

    typedef enum logic [2:0] {sizeZero, size8, size16, size32, size64} memSizeT;

    typedef enum logic [2:0] {
        wbNoHandle, wbZext8, wbZext16, wbZext32, wbZext64, wbSext8, wbSext16, wbSext32
    } wbKindT;

    typedef enum logic [3:0] {
        brNone, brEq, brNe, brLtS, brLtU, brGeS, brGeU, brJal, brJalr
    } branchT;

    typedef struct packed {
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        logic    memToReg;
        logic    readCsr;
        logic    writeCsr;
        logic    isCsr;
        logic    csrFromZimm;
        aluFuncT aluFunc;
        aluSrcT  aluSrc;
        immKindT immKind;
        memSizeT memSize;
        wbKindT  wbKind;
        branchT  branchType;
    } ctlT;

endpackage

`default_nettype wire

//--- common/decode_defs.svh
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// word and field widths
`define XLEN        64
`define ILEN        32
`define OPC_W       7
`define REG_W       5
`define F3_W        3
`define F7_W        7
`define F7_ALT_BIT  30

// major opcodes
`define OPC_OP_IMM     7'b0010011
`define OPC_OP         7'b0110011
`define OPC_OP_IMM_32  7'b0011011
`define OPC_OP_32      7'b0111011
`define OPC_LOAD       7'b0000011
`define OPC_STORE      7'b0100011
`define OPC_BRANCH     7'b1100011
`define OPC_LUI        7'b0110111
`define OPC_AUIPC      7'b0010111
`define OPC_JAL        7'b1101111
`define OPC_JALR       7'b1100111
`define OPC_SYSTEM     7'b1110011

// arithmetic funct3, shared by the 64-bit and W forms
`define F3_ADD   3'b000
`define F3_SLL   3'b001
`define F3_SLT   3'b010
`define F3_SLTU  3'b011
`define F3_XOR   3'b100
`define F3_SR    3'b101
`define F3_OR    3'b110
`define F3_AND   3'b111

// loads
`define F3_LB   3'b000
`define F3_LH   3'b001
`define F3_LW   3'b010
`define F3_LD   3'b011
`define F3_LBU  3'b100
`define F3_LHU  3'b101
`define F3_LWU  3'b110

// stores
`define F3_SB  3'b000
`define F3_SH  3'b001
`define F3_SW  3'b010
`define F3_SD  3'b011

// branches
`define F3_BEQ   3'b000
`define F3_BNE   3'b001
`define F3_BLT   3'b100
`define F3_BGE   3'b101
`define F3_BLTU  3'b110
`define F3_BGEU  3'b111

// zicsr
`define F3_CSRRW   3'b001
`define F3_CSRRS   3'b010
`define F3_CSRRC   3'b011
`define F3_CSRRWI  3'b101
`define F3_CSRRSI  3'b110
`define F3_CSRRCI  3'b111

`endif

//--- decodeStage.f
+incdir+common
common/decodePkg.sv
source/decodeStage.sv
decoder/opcodeControl.sv
decoder/aluDecode.sv
decoder/memBranchDecode.sv
decoder/immGen.sv
bench/decodeStageTb.sv

//--- decoder/aluDecode.sv
`timescale 1ns/10ps
`default_nettype none

`include "decode_defs.svh"

module aluDecode (
    input  decodePkg::instrWordU  instr,
    input  decodePkg::instrClassT instrClass,
    output decodePkg::aluFuncT    aluFunc,
    output decodePkg::aluSrcT     aluSrc
);

    logic [`F3_W-1:0] f3;
    logic             alt;

    assign f3  = instr.rType.funct3;
    assign alt = instr[`F7_ALT_BIT];

    always_comb begin
        aluFunc = decodePkg::aluUnknown;
        aluSrc  = decodePkg::noSrc;
        case (instrClass)
            decodePkg::opImm: begin
                aluSrc = decodePkg::fromImm;
                case (f3)
                    `F3_ADD:  aluFunc = decodePkg::aluAdd;
                    `F3_SLT:  aluFunc = decodePkg::aluSlt;
                    `F3_SLTU: aluFunc = decodePkg::aluSltu;
                    `F3_XOR:  aluFunc = decodePkg::aluXor;
                    `F3_OR:   aluFunc = decodePkg::aluOr;
                    `F3_AND:  aluFunc = decodePkg::aluAnd;
                    `F3_SLL: begin
                        aluFunc = decodePkg::aluSll;
                        aluSrc  = decodePkg::fromShamt;
                    end
                    default: begin
                        // srli or srai
                        aluFunc = alt ? decodePkg::aluSra : decodePkg::aluSrl;
                        aluSrc  = decodePkg::fromShamt;
                    end
                endcase
            end
            decodePkg::op: begin
                aluSrc = decodePkg::fromReg;
                case (f3)
                    `F3_ADD:  aluFunc = alt ? decodePkg::aluSub : decodePkg::aluAdd;
                    `F3_SLL:  aluFunc = decodePkg::aluSll;
                    `F3_SLT:  aluFunc = decodePkg::aluSlt;
                    `F3_SLTU: aluFunc = decodePkg::aluSltu;
                    `F3_XOR:  aluFunc = decodePkg::aluXor;
                    `F3_SR:   aluFunc = alt ? decodePkg::aluSra : decodePkg::aluSrl;
                    `F3_OR:   aluFunc = decodePkg::aluOr;
                    default:  aluFunc = decodePkg::aluAnd;
                endcase
            end
            decodePkg::opImm32: begin
                case (f3)
                    `F3_ADD: begin
                        aluFunc = decodePkg::aluAddw;
                        aluSrc  = decodePkg::fromImm;
                    end
                    `F3_SLL: begin
                        aluFunc = decodePkg::aluSllw;
                        aluSrc  = decodePkg::fromShamt;
                    end
                    `F3_SR: begin
                        aluFunc = alt ? decodePkg::aluSraw : decodePkg::aluSrlw;
                        aluSrc  = decodePkg::fromShamt;
                    end
                    default: ;
                endcase
            end
            decodePkg::op32: begin
                aluSrc = decodePkg::fromReg;
                case (f3)
                    `F3_ADD: aluFunc = alt ? decodePkg::aluSubw : decodePkg::aluAddw;
                    `F3_SLL: aluFunc = decodePkg::aluSllw;
                    `F3_SR:  aluFunc = alt ? decodePkg::aluSraw : decodePkg::aluSrlw;
                    default: ;
                endcase
            end
            decodePkg::load, decodePkg::store: begin
                // effective address = rs1 + offset
                aluFunc = decodePkg::aluAdd;
                aluSrc  = decodePkg::fromImm;
            end
            decodePkg::branch: begin
                aluFunc = decodePkg::aluBranch;
                aluSrc  = decodePkg::fromReg;
            end
            decodePkg::lui: begin
                aluFunc = decodePkg::aluLink;
                aluSrc  = decodePkg::fromImm;
            end
            decodePkg::auipc: begin
                aluFunc = decodePkg::aluLink;
                aluSrc  = decodePkg::fromPcAddImm;
            end
            decodePkg::jal, decodePkg::jalr: begin
                aluFunc = decodePkg::aluLink;
                aluSrc  = decodePkg::fromPcAdd4;
            end
            decodePkg::csr: begin
                aluSrc = decodePkg::fromCsr;
                case (f3)
                    `F3_CSRRW, `F3_CSRRWI: aluFunc = decodePkg::aluPassRs1;
                    `F3_CSRRS, `F3_CSRRSI: aluFunc = decodePkg::aluOr;
                    `F3_CSRRC, `F3_CSRRCI: aluFunc = decodePkg::aluAnd;
                    default: ;
                endcase
            end
            default: aluSrc = decodePkg::fromReg;
        endcase
    end

endmodule

`default_nettype wire

//--- decoder/immGen.sv
`timescale 1ns/10ps
`default_nettype none

`include "decode_defs.svh"

module immGen (
    input  decodePkg::instrWordU instr,
    input  decodePkg::immKindT   immKind,
    output decodePkg::xWord      imm
);

    logic sign;

    // every signed format keeps its sign in the top bit
    assign sign = instr[`ILEN-1];

    always_comb begin
        case (immKind)
            decodePkg::iImm:
                imm = {{(`XLEN-12){sign}}, instr.iType.imm};
            decodePkg::sImm:
                imm = {{(`XLEN-12){sign}}, instr.sType.immHi, instr.sType.immLo};
            decodePkg::bImm:
                imm = {{(`XLEN-13){sign}}, instr.bType.imm12, instr.bType.imm11,
                       instr.bType.imm10to5, instr.bType.imm4to1, 1'b0};
            decodePkg::uImm:
                imm = {{(`XLEN-32){sign}}, instr.uType.imm, 12'b0};
            decodePkg::jImm:
                imm = {{(`XLEN-21){sign}}, instr.jType.imm20, instr.jType.imm19to12,
                       instr.jType.imm11, instr.jType.imm10to1, 1'b0};
            // zimm sits in the rs1 slot, unsigned
            decodePkg::csrZimm:
                imm = {{(`XLEN-`REG_W){1'b0}}, instr.iType.rs1};
            default:
                imm = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- decoder/memBranchDecode.sv
`timescale 1ns/10ps
`default_nettype none

`include "decode_defs.svh"

module memBranchDecode (
    input  decodePkg::instrWordU  instr,
    input  decodePkg::instrClassT instrClass,
    output decodePkg::memSizeT    memSize,
    output decodePkg::wbKindT     wbKind,
    output decodePkg::branchT     branchType
);

    logic [`F3_W-1:0] f3;

    assign f3 = instr.rType.funct3;

    always_comb begin
        // bad funct3 under load/store leaves these at zero
        memSize    = decodePkg::sizeZero;
        wbKind     = decodePkg::wbNoHandle;
        branchType = decodePkg::brNone;
        case (instrClass)
            decodePkg::load: begin
                case (f3)
                    `F3_LB: begin
                        memSize = decodePkg::size8;
                        wbKind  = decodePkg::wbSext8;
                    end
                    `F3_LH: begin
                        memSize = decodePkg::size16;
                        wbKind  = decodePkg::wbSext16;
                    end
                    `F3_LW: begin
                        memSize = decodePkg::size32;
                        wbKind  = decodePkg::wbSext32;
                    end
                    `F3_LD: begin
                        memSize = decodePkg::size64;
                        wbKind  = decodePkg::wbZext64;
                    end
                    `F3_LBU: begin
                        memSize = decodePkg::size8;
                        wbKind  = decodePkg::wbZext8;
                    end
                    `F3_LHU: begin
                        memSize = decodePkg::size16;
                        wbKind  = decodePkg::wbZext16;
                    end
                    `F3_LWU: begin
                        memSize = decodePkg::size32;
                        wbKind  = decodePkg::wbZext32;
                    end
                    default: ;
                endcase
            end
            decodePkg::store: begin
                case (f3)
                    `F3_SB:  memSize = decodePkg::size8;
                    `F3_SH:  memSize = decodePkg::size16;
                    `F3_SW:  memSize = decodePkg::size32;
                    `F3_SD:  memSize = decodePkg::size64;
                    default: ;
                endcase
            end
            decodePkg::branch: begin
                case (f3)
                    `F3_BEQ:  branchType = decodePkg::brEq;
                    `F3_BNE:  branchType = decodePkg::brNe;
                    `F3_BLT:  branchType = decodePkg::brLtS;
                    `F3_BGE:  branchType = decodePkg::brGeS;
                    `F3_BLTU: branchType = decodePkg::brLtU;
                    `F3_BGEU: branchType = decodePkg::brGeU;
                    default: ;
                endcase
            end
            decodePkg::jal:  branchType = decodePkg::brJal;
            decodePkg::jalr: branchType = decodePkg::brJalr;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- decoder/opcodeControl.sv
`timescale 1ns/10ps
`default_nettype none

`include "decode_defs.svh"

module opcodeControl (
    input  decodePkg::instrWordU  instr,
    output decodePkg::instrClassT instrClass,
    output decodePkg::regUseT     regUse,
    output decodePkg::immKindT    immKind,
    output logic                  regWrite,
    output logic                  memRead,
    output logic                  memWrite,
    output logic                  memToReg,
    output logic                  readCsr,
    output logic                  writeCsr,
    output logic                  isCsr,
    output logic                  csrFromZimm
);

    logic [`F3_W-1:0] f3;

    assign f3 = instr.iType.funct3;

    always_comb begin
        // unknown opcode falls through with everything low
        instrClass  = decodePkg::illegal;
        regUse      = decodePkg::noRs;
        immKind     = decodePkg::immNone;
        regWrite    = 1'b0;
        memRead     = 1'b0;
        memWrite    = 1'b0;
        memToReg    = 1'b0;
        readCsr     = 1'b0;
        writeCsr    = 1'b0;
        isCsr       = 1'b0;
        csrFromZimm = 1'b0;
        case (instr.rType.opcode)
            `OPC_OP_IMM: begin
                instrClass = decodePkg::opImm;
                regWrite   = 1'b1;
                regUse     = decodePkg::onlyRs1;
                // shifts read shamt, not the immediate
                if (f3 != `F3_SLL && f3 != `F3_SR) begin
                    immKind = decodePkg::iImm;
                end
            end
            `OPC_OP: begin
                instrClass = decodePkg::op;
                regWrite   = 1'b1;
                regUse     = decodePkg::bothRs;
            end
            `OPC_OP_IMM_32: begin
                instrClass = decodePkg::opImm32;
                regWrite   = 1'b1;
                regUse     = decodePkg::onlyRs1;
                if (f3 == `F3_ADD) begin
                    immKind = decodePkg::iImm;
                end
            end
            `OPC_OP_32: begin
                instrClass = decodePkg::op32;
                regWrite   = 1'b1;
                regUse     = decodePkg::bothRs;
            end
            `OPC_LOAD: begin
                instrClass = decodePkg::load;
                regWrite   = 1'b1;
                memRead    = 1'b1;
                memToReg   = 1'b1;
                regUse     = decodePkg::onlyRs1;
                immKind    = decodePkg::iImm;
            end
            `OPC_STORE: begin
                instrClass = decodePkg::store;
                memWrite   = 1'b1;
                regUse     = decodePkg::bothRs;
                immKind    = decodePkg::sImm;
            end
            `OPC_BRANCH: begin
                instrClass = decodePkg::branch;
                regUse     = decodePkg::bothRs;
                immKind    = decodePkg::bImm;
            end
            `OPC_LUI, `OPC_AUIPC: begin
                instrClass = (instr.rType.opcode == `OPC_LUI) ? decodePkg::lui
                                                              : decodePkg::auipc;
                regWrite   = 1'b1;
                immKind    = decodePkg::uImm;
            end
            `OPC_JAL: begin
                instrClass = decodePkg::jal;
                regWrite   = 1'b1;
                immKind    = decodePkg::jImm;
            end
            `OPC_JALR: begin
                instrClass = decodePkg::jalr;
                regWrite   = 1'b1;
                regUse     = decodePkg::onlyRs1;
                immKind    = decodePkg::iImm;
            end
            `OPC_SYSTEM: begin
                instrClass = decodePkg::csr;
                regWrite   = 1'b1;
                readCsr    = 1'b1;
                writeCsr   = 1'b1;
                isCsr      = 1'b1;
                // funct3 low bits of zero are not a csr op
                if (f3[1:0] != 2'b00) begin
                    if (f3[2]) begin
                        immKind     = decodePkg::csrZimm;
                        csrFromZimm = 1'b1;
                    end else begin
                        regUse = decodePkg::onlyRs1;
                    end
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- runSim.sh
#!/usr/bin/env bash
# builds and runs the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -f decodeStage.f \
    --top-module decodeStageTb --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VdecodeStageTb > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "Test OK" "$logFile"; then
    exit 0
fi
echo "pass message not found in $logFile"
exit 1

//--- source/decodeStage.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStage (
    input  wire                   clk,
    input  wire                   rstN,
    input  decodePkg::instrWordU  instr,
    input  wire                   instrValid,
    output logic                  outValid,
    output decodePkg::ctlT        ctl,
    output decodePkg::regUseT     regUse,
    output decodePkg::xWord       imm
);

    decodePkg::instrClassT instrClass;
    decodePkg::ctlT        ctlNext;
    decodePkg::regUseT     regUseNext;
    decodePkg::xWord       immNext;

    // class-wide flags land straight in the control word
    opcodeControl uOpcodeControl (
        .instr       (instr),
        .instrClass  (instrClass),
        .regUse      (regUseNext),
        .immKind     (ctlNext.immKind),
        .regWrite    (ctlNext.regWrite),
        .memRead     (ctlNext.memRead),
        .memWrite    (ctlNext.memWrite),
        .memToReg    (ctlNext.memToReg),
        .readCsr     (ctlNext.readCsr),
        .writeCsr    (ctlNext.writeCsr),
        .isCsr       (ctlNext.isCsr),
        .csrFromZimm (ctlNext.csrFromZimm)
    );

    aluDecode uAluDecode (
        .instr      (instr),
        .instrClass (instrClass),
        .aluFunc    (ctlNext.aluFunc),
        .aluSrc     (ctlNext.aluSrc)
    );

    memBranchDecode uMemBranchDecode (
        .instr      (instr),
        .instrClass (instrClass),
        .memSize    (ctlNext.memSize),
        .wbKind     (ctlNext.wbKind),
        .branchType (ctlNext.branchType)
    );

    immGen uImmGen (
        .instr   (instr),
        .immKind (ctlNext.immKind),
        .imm     (immNext)
    );

    // decode latch, data holds while nothing valid arrives
    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
            ctl      <= '0;
            regUse   <= decodePkg::noRs;
            imm      <= '0;
        end else begin
            outValid <= instrValid;
            if (instrValid) begin
                ctl    <= ctlNext;
                regUse <= regUseNext;
                imm    <= immNext;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> !(ctl.memRead && ctl.memWrite))
        else $error("decodeStage: memRead and memWrite both set");

    assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> (!ctl.writeCsr || ctl.isCsr))
        else $error("decodeStage: CSR write outside a CSR instruction");

endmodule

`default_nettype wire
